// ==== rob_pkg.sv ====
// reorder buffer sizes, register and index types, entry record
`default_nettype none

package rob_pkg;

    // default buffer size, the top level may override it
    localparam int unsigned ROB_DEPTH = 8;

    // register file sizes
    localparam int unsigned ARCH_REGS = 32;
    localparam int unsigned PHYS_REGS = 64;

    // result width
    localparam int unsigned XLEN = 32;

    // default number of functional unit writeback ports
    localparam int unsigned WB_WIDTH = 2;

    // index into the buffer, wraps naturally for power-of-two depths
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;

    // occupancy, one bit wider so a full buffer fits
    typedef logic [$clog2(ROB_DEPTH):0] rob_cnt_t;

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;

    // one bit per physical register, used for freeing after a flush
    typedef logic [PHYS_REGS-1:0] phys_mask_t;

    // one buffer slot as seen at the head
    typedef struct packed {
        logic            valid;
        logic            done;
        logic            rd_wen;
        arch_reg_t       rd_arch;
        phys_reg_t       new_prf;
        phys_reg_t       old_prf;
        logic [XLEN-1:0] value;
    } rob_entry_t;

endpackage

`default_nettype wire

// ==== rob_entry_table.sv ====
// reorder buffer entry storage: dispatch write, writeback update, head read, flush clear
`timescale 1ns/10ps
`default_nettype none

module rob_entry_table
    import rob_pkg::*;
#(
    parameter int unsigned ROB_DEPTH = rob_pkg::ROB_DEPTH,
    parameter int unsigned WB_WIDTH  = rob_pkg::WB_WIDTH,
    localparam int unsigned IDX_W    = $clog2(ROB_DEPTH)
) (
    input  wire logic                               clock,
    input  wire logic                               reset,
    // allocation at the tail
    input  wire logic                               alloc_i,
    input  wire logic [IDX_W-1:0]                   alloc_idx_i,
    input  wire logic                               disp_rd_wen_i,
    input  wire arch_reg_t                          disp_rd_arch_i,
    input  wire phys_reg_t                          disp_new_prf_i,
    input  wire phys_reg_t                          disp_old_prf_i,
    // functional unit results
    input  wire logic [WB_WIDTH-1:0]                wb_valid_i,
    input  wire logic [WB_WIDTH-1:0][IDX_W-1:0]     wb_rob_idx_i,
    input  wire logic [WB_WIDTH-1:0][XLEN-1:0]      wb_value_i,
    // retirement at the head
    input  wire logic                               retire_i,
    input  wire logic [IDX_W-1:0]                   head_i,
    // entries killed by a mispredict
    input  wire logic [ROB_DEPTH-1:0]               flush_mask_i,
    output rob_entry_t                              head_entry_o,
    output logic [ROB_DEPTH-1:0]                    valid_vec_o,
    output logic [ROB_DEPTH-1:0]                    rd_wen_vec_o,
    output phys_reg_t [ROB_DEPTH-1:0]               new_prf_vec_o
);

    // control bits, cleared by reset
    logic [ROB_DEPTH-1:0] valid_q;
    logic [ROB_DEPTH-1:0] valid_d;
    logic [ROB_DEPTH-1:0] done_q;
    logic [ROB_DEPTH-1:0] done_d;

    // payload columns
    logic [ROB_DEPTH-1:0]      rd_wen_q;
    phys_reg_t [ROB_DEPTH-1:0] new_prf_q;
    arch_reg_t                 rd_arch_q [ROB_DEPTH];
    phys_reg_t                 old_prf_q [ROB_DEPTH];
    logic [XLEN-1:0]           value_q   [ROB_DEPTH];

    // writeback beat lands on a live entry
    logic [WB_WIDTH-1:0] wb_hit;

    always_comb begin
        for (int w = 0; w < WB_WIDTH; w++) begin
            wb_hit[w] = wb_valid_i[w] && valid_q[wb_rob_idx_i[w]];
        end
    end

    // next state of valid/done
    // order: writeback, retire, flush, then allocate
    always_comb begin
        valid_d = valid_q;
        done_d  = done_q;
        for (int w = 0; w < WB_WIDTH; w++) begin
            if (wb_hit[w]) begin
                done_d[wb_rob_idx_i[w]] = 1'b1;
            end
        end
        if (retire_i) begin
            valid_d[head_i] = 1'b0;
            done_d[head_i]  = 1'b0;
        end
        valid_d = valid_d & ~flush_mask_i;
        done_d  = done_d & ~flush_mask_i;
        // new entry starts not done
        if (alloc_i) begin
            valid_d[alloc_idx_i] = 1'b1;
            done_d[alloc_idx_i]  = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            valid_q <= valid_d;
            done_q  <= done_d;
        end
    end

    // payload, qualified by valid everywhere it is read
    always_ff @(posedge clock) begin
        if (alloc_i) begin
            rd_wen_q[alloc_idx_i]  <= disp_rd_wen_i;
            rd_arch_q[alloc_idx_i] <= disp_rd_arch_i;
            new_prf_q[alloc_idx_i] <= disp_new_prf_i;
            old_prf_q[alloc_idx_i] <= disp_old_prf_i;
        end
        for (int w = 0; w < WB_WIDTH; w++) begin
            if (wb_hit[w]) begin
                value_q[wb_rob_idx_i[w]] <= wb_value_i[w];
            end
        end
    end

    // head slot for commit
    always_comb begin
        head_entry_o.valid   = valid_q[head_i];
        head_entry_o.done    = done_q[head_i];
        head_entry_o.rd_wen  = rd_wen_q[head_i];
        head_entry_o.rd_arch = rd_arch_q[head_i];
        head_entry_o.new_prf = new_prf_q[head_i];
        head_entry_o.old_prf = old_prf_q[head_i];
        head_entry_o.value   = value_q[head_i];
    end

    // columns for the flush walk
    assign valid_vec_o   = valid_q;
    assign rd_wen_vec_o  = rd_wen_q;
    assign new_prf_vec_o = new_prf_q;

    // tail pointer must only ever land on a free slot
    assert property (@(posedge clock) disable iff (reset)
        alloc_i |-> !valid_q[alloc_idx_i]);

endmodule

`default_nettype wire

// ==== rob_pointer_ctrl.sv ====
// reorder buffer head, tail and count registers with dispatch and commit handshakes
`timescale 1ns/10ps
`default_nettype none

module rob_pointer_ctrl
    import rob_pkg::*;
#(
    parameter int unsigned ROB_DEPTH = rob_pkg::ROB_DEPTH,
    localparam int unsigned IDX_W    = $clog2(ROB_DEPTH),
    localparam int unsigned CNT_W    = IDX_W + 1
) (
    input  wire logic              clock,
    input  wire logic              reset,
    // dispatch handshake
    input  wire logic              disp_valid_i,
    output logic                   disp_ready_o,
    output logic [IDX_W-1:0]       disp_rob_idx_o,
    output logic                   alloc_o,
    // head slot state
    input  wire rob_entry_t        head_entry_i,
    // commit handshake
    input  wire logic              commit_ready_i,
    output logic                   commit_valid_o,
    output logic                   retire_o,
    output logic [IDX_W-1:0]       head_o,
    output logic [IDX_W-1:0]       tail_o,
    // mispredict recovery
    input  wire logic              mispredict_i,
    input  wire logic [IDX_W-1:0]  mispredict_rob_idx_i,
    input  wire logic [CNT_W-1:0]  flush_count_i
);

    logic [IDX_W-1:0] head_q;
    logic [IDX_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;
    logic             full;

    assign full = (count_q == CNT_W'(ROB_DEPTH));

    // no allocation in a mispredict cycle, the tail is being rewound
    assign disp_ready_o   = !full && !mispredict_i;
    assign alloc_o        = disp_valid_i && disp_ready_o;
    // tail is shown all the time so the index is there in the transfer cycle
    assign disp_rob_idx_o = tail_q;

    // oldest entry retires once done
    // held low during a mispredict
    assign commit_valid_o = head_entry_i.valid && head_entry_i.done && !mispredict_i;
    assign retire_o       = commit_valid_o && commit_ready_i;

    assign head_o = head_q;
    assign tail_o = tail_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (mispredict_i) begin
            // everything younger than the branch is gone
            tail_q  <= mispredict_rob_idx_i + 1'b1;
            count_q <= count_q - flush_count_i;
        end else begin
            if (retire_o) begin
                head_q <= head_q + 1'b1;
            end
            if (alloc_o) begin
                tail_q <= tail_q + 1'b1;
            end
            // occupancy moves by at most one
            case ({alloc_o, retire_o})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // occupancy bound, also checks the flush count from the walk
    assert property (@(posedge clock) disable iff (reset)
        count_q <= CNT_W'(ROB_DEPTH));

    // a done head with nothing counted means the table and pointers disagree
    assert property (@(posedge clock) disable iff (reset)
        retire_o |-> (count_q != '0));

endmodule

`default_nettype wire

// ==== rob_flush_walk.sv ====
// reorder buffer mispredict walk: flush mask, flush count and registered free mask
`timescale 1ns/10ps
`default_nettype none

module rob_flush_walk
    import rob_pkg::*;
#(
    parameter int unsigned ROB_DEPTH = rob_pkg::ROB_DEPTH,
    localparam int unsigned IDX_W    = $clog2(ROB_DEPTH),
    localparam int unsigned CNT_W    = IDX_W + 1
) (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      mispredict_i,
    input  wire logic [IDX_W-1:0]          mispredict_rob_idx_i,
    input  wire logic [IDX_W-1:0]          tail_i,
    input  wire logic [ROB_DEPTH-1:0]      valid_vec_i,
    input  wire logic [ROB_DEPTH-1:0]      rd_wen_vec_i,
    input  wire phys_reg_t [ROB_DEPTH-1:0] new_prf_vec_i,
    output logic [ROB_DEPTH-1:0]           flush_mask_o,
    output logic [CNT_W-1:0]               flush_count_o,
    output logic                           flush_free_valid_o,
    output phys_mask_t                     flush_free_mask_o
);

    phys_mask_t free_mask;

    // walk from the slot after the branch until the tail
    always_comb begin
        logic [IDX_W-1:0] idx;
        logic             active;
        flush_mask_o  = '0;
        flush_count_o = '0;
        free_mask     = '0;
        active        = mispredict_i;
        for (int j = 1; j < ROB_DEPTH; j++) begin
            idx = mispredict_rob_idx_i + IDX_W'(j);
            // stop at the first free slot past the youngest entry
            if (idx == tail_i) begin
                active = 1'b0;
            end
            if (active && valid_vec_i[idx]) begin
                flush_mask_o[idx] = 1'b1;
                flush_count_o     = flush_count_o + 1'b1;
                // only a renamed destination gives a register back
                if (rd_wen_vec_i[idx]) begin
                    free_mask[new_prf_vec_i[idx]] = 1'b1;
                end
            end
        end
    end

    // one-cycle pulse to the free list
    always_ff @(posedge clock) begin
        if (reset) begin
            flush_free_valid_o <= 1'b0;
        end else begin
            flush_free_valid_o <= mispredict_i;
        end
    end

    // mask held until the next mispredict
    always_ff @(posedge clock) begin
        if (mispredict_i) begin
            flush_free_mask_o <= free_mask;
        end
    end

    // the branch itself must still be in flight
    assert property (@(posedge clock) disable iff (reset)
        mispredict_i |-> valid_vec_i[mispredict_rob_idx_i]);

endmodule

`default_nettype wire

// ==== rob.sv ====
// reorder buffer top level: pointer control, entry table and flush walk
`timescale 1ns/10ps
`default_nettype none

module rob
    import rob_pkg::*;
#(
    parameter int unsigned ROB_DEPTH = rob_pkg::ROB_DEPTH,
    parameter int unsigned WB_WIDTH  = rob_pkg::WB_WIDTH,
    localparam int unsigned IDX_W    = $clog2(ROB_DEPTH),
    localparam int unsigned CNT_W    = IDX_W + 1
) (
    input  wire logic                           clock,
    input  wire logic                           reset,
    // dispatch
    input  wire logic                           disp_valid_i,
    input  wire logic                           disp_rd_wen_i,
    input  wire arch_reg_t                      disp_rd_arch_i,
    input  wire phys_reg_t                      disp_new_prf_i,
    input  wire phys_reg_t                      disp_old_prf_i,
    output logic                                disp_ready_o,
    output logic [IDX_W-1:0]                    disp_rob_idx_o,
    // writeback, no back-pressure
    input  wire logic [WB_WIDTH-1:0]            wb_valid_i,
    input  wire logic [WB_WIDTH-1:0][IDX_W-1:0] wb_rob_idx_i,
    input  wire logic [WB_WIDTH-1:0][XLEN-1:0]  wb_value_i,
    // commit
    output logic                                commit_valid_o,
    output logic                                commit_rd_wen_o,
    output arch_reg_t                           commit_rd_arch_o,
    output phys_reg_t                           commit_new_prf_o,
    output phys_reg_t                           commit_old_prf_o,
    output logic [XLEN-1:0]                     commit_value_o,
    input  wire logic                           commit_ready_i,
    // branch recovery
    input  wire logic                           mispredict_i,
    input  wire logic [IDX_W-1:0]               mispredict_rob_idx_i,
    output logic                                flush_free_valid_o,
    output phys_mask_t                          flush_free_mask_o
);

    logic [IDX_W-1:0]          head;
    logic [IDX_W-1:0]          tail;
    logic                      alloc;
    logic                      retire;
    rob_entry_t                head_entry;
    logic [ROB_DEPTH-1:0]      valid_vec;
    logic [ROB_DEPTH-1:0]      rd_wen_vec;
    phys_reg_t [ROB_DEPTH-1:0] new_prf_vec;
    logic [ROB_DEPTH-1:0]      flush_mask;
    logic [CNT_W-1:0]          flush_count;

    rob_pointer_ctrl #(
        .ROB_DEPTH (ROB_DEPTH)
    ) pointer_ctrl_i (
        .clock                (clock),
        .reset                (reset),
        .disp_valid_i         (disp_valid_i),
        .disp_ready_o         (disp_ready_o),
        .disp_rob_idx_o       (disp_rob_idx_o),
        .alloc_o              (alloc),
        .head_entry_i         (head_entry),
        .commit_ready_i       (commit_ready_i),
        .commit_valid_o       (commit_valid_o),
        .retire_o             (retire),
        .head_o               (head),
        .tail_o               (tail),
        .mispredict_i         (mispredict_i),
        .mispredict_rob_idx_i (mispredict_rob_idx_i),
        .flush_count_i        (flush_count)
    );

    // new entries always go in at the tail
    rob_entry_table #(
        .ROB_DEPTH (ROB_DEPTH),
        .WB_WIDTH  (WB_WIDTH)
    ) entry_table_i (
        .clock          (clock),
        .reset          (reset),
        .alloc_i        (alloc),
        .alloc_idx_i    (tail),
        .disp_rd_wen_i  (disp_rd_wen_i),
        .disp_rd_arch_i (disp_rd_arch_i),
        .disp_new_prf_i (disp_new_prf_i),
        .disp_old_prf_i (disp_old_prf_i),
        .wb_valid_i     (wb_valid_i),
        .wb_rob_idx_i   (wb_rob_idx_i),
        .wb_value_i     (wb_value_i),
        .retire_i       (retire),
        .head_i         (head),
        .flush_mask_i   (flush_mask),
        .head_entry_o   (head_entry),
        .valid_vec_o    (valid_vec),
        .rd_wen_vec_o   (rd_wen_vec),
        .new_prf_vec_o  (new_prf_vec)
    );

    rob_flush_walk #(
        .ROB_DEPTH (ROB_DEPTH)
    ) flush_walk_i (
        .clock                (clock),
        .reset                (reset),
        .mispredict_i         (mispredict_i),
        .mispredict_rob_idx_i (mispredict_rob_idx_i),
        .tail_i               (tail),
        .valid_vec_i          (valid_vec),
        .rd_wen_vec_i         (rd_wen_vec),
        .new_prf_vec_i        (new_prf_vec),
        .flush_mask_o         (flush_mask),
        .flush_count_o        (flush_count),
        .flush_free_valid_o   (flush_free_valid_o),
        .flush_free_mask_o    (flush_free_mask_o)
    );

    // commit fields straight from the head slot
    // stable under back-pressure since the head holds
    assign commit_rd_wen_o  = head_entry.rd_wen;
    assign commit_rd_arch_o = head_entry.rd_arch;
    assign commit_new_prf_o = head_entry.new_prf;
    assign commit_old_prf_o = head_entry.old_prf;
    assign commit_value_o   = head_entry.value;

endmodule

`default_nettype wire

// ==== rob_checker.sv ====
// reorder buffer checker: dispatch index, commit record, free mask and stall stability
`timescale 1ns/10ps
`default_nettype none

module rob_checker
    import rob_pkg::*;
#(
    parameter int unsigned ROB_DEPTH = rob_pkg::ROB_DEPTH,
    localparam int unsigned IDX_W    = $clog2(ROB_DEPTH)
) (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             disp_valid_i,
    input  wire logic             disp_ready_i,
    input  wire logic [IDX_W-1:0] disp_rob_idx_i,
    input  wire logic             commit_valid_i,
    input  wire logic             commit_ready_i,
    input  wire logic             commit_rd_wen_i,
    input  wire arch_reg_t        commit_rd_arch_i,
    input  wire phys_reg_t        commit_new_prf_i,
    input  wire phys_reg_t        commit_old_prf_i,
    input  wire logic [XLEN-1:0]  commit_value_i,
    input  wire logic             mispredict_i,
    input  wire logic             flush_free_valid_i,
    input  wire phys_mask_t       flush_free_mask_i
);

    // commit record packs rd_wen, arch, new, old and value
    logic [49:0]      exp_commit [$];
    logic [IDX_W-1:0] exp_index  [$];
    phys_mask_t       exp_free   [$];
    logic [49:0]      actual;
    logic [49:0]      held;
    logic             stalled;
    int               error_count = 0;

    task automatic add_commit(input logic [49:0] rec);
        exp_commit.push_back(rec);
    endtask

    task automatic add_index(input logic [IDX_W-1:0] idx);
        exp_index.push_back(idx);
    endtask

    task automatic add_free(input phys_mask_t mask);
        exp_free.push_back(mask);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        $display("FAILED %s: expected %0h, actual %0h", name, exp_v, act_v);
        error_count = error_count + 1;
    endtask

    // anything left over means the DUT lost work
    task automatic final_check();
        if (exp_commit.size() != 0 || exp_index.size() != 0 || exp_free.size() != 0) begin
            $display("%0d commits, %0d dispatches and %0d free masks never arrived",
                     exp_commit.size(), exp_index.size(), exp_free.size());
            error_count = error_count + 1;
        end
    endtask

    assign actual = {commit_rd_wen_i, commit_rd_arch_i, commit_new_prf_i,
                     commit_old_prf_i, commit_value_i};

    always @(posedge clock) begin
        if (reset) begin
            stalled <= 1'b0;
        end else begin
            if (disp_valid_i && disp_ready_i) begin
                if (exp_index.size() == 0) begin
                    $display("a dispatch was accepted with no index expected");
                    error_count = error_count + 1;
                end else if (exp_index[0] !== disp_rob_idx_i) begin
                    report_mismatch("dispatch_index", 64'(exp_index[0]), 64'(disp_rob_idx_i));
                end
                if (exp_index.size() != 0) begin
                    void'(exp_index.pop_front());
                end
            end
            // stalled head keeps its outputs
            if (stalled && !mispredict_i) begin
                if (!commit_valid_i || actual !== held) begin
                    report_mismatch("commit_stall_hold", 64'(held), 64'(actual));
                end
            end
            if (commit_valid_i && commit_ready_i) begin
                if (exp_commit.size() == 0) begin
                    $display("an entry committed with no commit expected");
                    error_count = error_count + 1;
                end else begin
                    if (exp_commit[0] !== actual) begin
                        report_mismatch("commit_record", 64'(exp_commit[0]), 64'(actual));
                    end
                    void'(exp_commit.pop_front());
                end
            end
            if (flush_free_valid_i) begin
                if (exp_free.size() == 0) begin
                    $display("a free mask was sent with no flush expected");
                    error_count = error_count + 1;
                end else begin
                    if (exp_free[0] !== flush_free_mask_i) begin
                        report_mismatch("flush_free_mask", exp_free[0], flush_free_mask_i);
                    end
                    void'(exp_free.pop_front());
                end
            end
            stalled <= commit_valid_i && !commit_ready_i;
            held    <= actual;
        end
    end

endmodule

`default_nettype wire

// ==== tb_rob.sv ====
// reorder buffer testbench top: clock, reset, pattern reader, stimulus, watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_rob
    import rob_pkg::*;
();

    localparam int DEPTH            = 8;
    localparam int WBW              = 2;
    localparam int IDX_W            = $clog2(DEPTH);
    localparam int MAX_LINES        = 64;
    localparam int WORDS_PER_LINE   = 5;
    localparam int TIMEOUT_PER_LINE = 40;

    logic                      clock;
    logic                      reset;
    logic                      disp_valid;
    logic                      disp_rd_wen;
    arch_reg_t                 disp_rd_arch;
    phys_reg_t                 disp_new_prf;
    phys_reg_t                 disp_old_prf;
    logic                      disp_ready;
    logic [IDX_W-1:0]          disp_rob_idx;
    logic [WBW-1:0]            wb_valid;
    logic [WBW-1:0][IDX_W-1:0] wb_rob_idx;
    logic [WBW-1:0][XLEN-1:0]  wb_value;
    logic                      commit_valid;
    logic                      commit_rd_wen;
    arch_reg_t                 commit_rd_arch;
    phys_reg_t                 commit_new_prf;
    phys_reg_t                 commit_old_prf;
    logic [XLEN-1:0]           commit_value;
    logic                      commit_ready;
    logic                      mispredict;
    logic [IDX_W-1:0]          mispredict_rob_idx;
    logic                      flush_free_valid;
    phys_mask_t                flush_free_mask;

    // five hex words per pattern line
    logic [63:0] pat [MAX_LINES*WORDS_PER_LINE];
    integer      seed = 32'h86ab7cdb;
    int          stall_cycles;
    int          ready_bits;
    int          line_count;
    int          tb_errors;

    rob #(
        .ROB_DEPTH (DEPTH),
        .WB_WIDTH  (WBW)
    ) rob_i (
        .clock                (clock),
        .reset                (reset),
        .disp_valid_i         (disp_valid),
        .disp_rd_wen_i        (disp_rd_wen),
        .disp_rd_arch_i       (disp_rd_arch),
        .disp_new_prf_i       (disp_new_prf),
        .disp_old_prf_i       (disp_old_prf),
        .disp_ready_o         (disp_ready),
        .disp_rob_idx_o       (disp_rob_idx),
        .wb_valid_i           (wb_valid),
        .wb_rob_idx_i         (wb_rob_idx),
        .wb_value_i           (wb_value),
        .commit_valid_o       (commit_valid),
        .commit_rd_wen_o      (commit_rd_wen),
        .commit_rd_arch_o     (commit_rd_arch),
        .commit_new_prf_o     (commit_new_prf),
        .commit_old_prf_o     (commit_old_prf),
        .commit_value_o       (commit_value),
        .commit_ready_i       (commit_ready),
        .mispredict_i         (mispredict),
        .mispredict_rob_idx_i (mispredict_rob_idx),
        .flush_free_valid_o   (flush_free_valid),
        .flush_free_mask_o    (flush_free_mask)
    );

    rob_checker #(
        .ROB_DEPTH (DEPTH)
    ) checker_i (
        .clock              (clock),
        .reset              (reset),
        .disp_valid_i       (disp_valid),
        .disp_ready_i       (disp_ready),
        .disp_rob_idx_i     (disp_rob_idx),
        .commit_valid_i     (commit_valid),
        .commit_ready_i     (commit_ready),
        .commit_rd_wen_i    (commit_rd_wen),
        .commit_rd_arch_i   (commit_rd_arch),
        .commit_new_prf_i   (commit_new_prf),
        .commit_old_prf_i   (commit_old_prf),
        .commit_value_i     (commit_value),
        .mispredict_i       (mispredict),
        .flush_free_valid_i (flush_free_valid),
        .flush_free_mask_i  (flush_free_mask)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // commit back-pressure, random unless a stall is pending
    always @(negedge clock) begin
        if (stall_cycles > 0) begin
            commit_ready = 1'b0;
            stall_cycles = stall_cycles - 1;
        end else begin
            ready_bits   = $random(seed);
            commit_ready = ready_bits[0];
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
            tb_errors = tb_errors + 1;
        end
    endtask

    // rd_wen of the dispatch line that carries the same registers
    function automatic logic dispatch_wen(input int n, input logic [63:0] arch,
                                          input logic [63:0] new_prf,
                                          input logic [63:0] old_prf);
        logic wen;
        wen = 1'bx;
        for (int i = 0; i < n; i++) begin
            if ((pat[i*WORDS_PER_LINE] == 64'd1 || pat[i*WORDS_PER_LINE] == 64'd2)
                && pat[i*WORDS_PER_LINE+1] == arch
                && pat[i*WORDS_PER_LINE+2] == new_prf
                && pat[i*WORDS_PER_LINE+3] == old_prf) begin
                wen = (pat[i*WORDS_PER_LINE] == 64'd1);
            end
        end
        return wen;
    endfunction

    // hold valid until the ready side accepts
    task automatic drive_dispatch(input logic wen, input int base);
        @(negedge clock);
        disp_valid   = 1'b1;
        disp_rd_wen  = wen;
        disp_rd_arch = pat[base+1][4:0];
        disp_new_prf = pat[base+2][5:0];
        disp_old_prf = pat[base+3][5:0];
        while (!disp_ready) begin
            @(negedge clock);
        end
        @(negedge clock);
        disp_valid = 1'b0;
    endtask

    task automatic drive_writeback(input int port, input int base);
        @(negedge clock);
        wb_valid[port]   = 1'b1;
        wb_rob_idx[port] = pat[base+2][IDX_W-1:0];
        wb_value[port]   = pat[base+3][XLEN-1:0];
        @(negedge clock);
        wb_valid[port] = 1'b0;
    endtask

    task automatic drive_mispredict(input logic [IDX_W-1:0] idx);
        @(negedge clock);
        mispredict         = 1'b1;
        mispredict_rob_idx = idx;
        @(negedge clock);
        mispredict = 1'b0;
    endtask

    // watchdog scaled by the number of pattern lines
    initial begin
        wait (line_count > 0);
        repeat (line_count * TIMEOUT_PER_LINE) @(posedge clock);
        $display("timeout: the pattern run did not finish in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        int b;
        int n;
        int gap;
        disp_valid = 1'b0;
        disp_rd_wen = 1'b0;
        disp_rd_arch = '0;
        disp_new_prf = '0;
        disp_old_prf = '0;
        wb_valid = '0;
        wb_rob_idx = '0;
        wb_value = '0;
        commit_ready = 1'b0;
        mispredict = 1'b0;
        mispredict_rob_idx = '0;
        reset = 1'b1;
        stall_cycles = 0;
        tb_errors = 0;
        line_count = 0;
        $readmemh("rob_patterns.txt", pat);
        n = 0;
        while (n < MAX_LINES && !$isunknown(pat[n*WORDS_PER_LINE])
               && pat[n*WORDS_PER_LINE] != 64'd0) begin
            n = n + 1;
        end
        // expected records go to the checker before the run
        for (int i = 0; i < n; i++) begin
            b = i * WORDS_PER_LINE;
            case (pat[b])
                64'd1, 64'd2: checker_i.add_index(pat[b+4][2:0]);
                64'd8: checker_i.add_commit({dispatch_wen(n, pat[b+1], pat[b+2], pat[b+3]),
                                             pat[b+1][4:0], pat[b+2][5:0],
                                             pat[b+3][5:0], pat[b+4][31:0]});
                64'd9: checker_i.add_free(pat[b+1]);
                default: ;
            endcase
        end
        line_count = n + 1;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        check_value("reset_commit_valid", 64'd0, 64'(commit_valid));
        check_value("reset_free_valid", 64'd0, 64'(flush_free_valid));
        check_value("reset_disp_ready", 64'd1, 64'(disp_ready));
        for (int i = 0; i < n; i++) begin
            b = i * WORDS_PER_LINE;
            case (pat[b])
                64'd1: drive_dispatch(1'b1, b);
                64'd2: drive_dispatch(1'b0, b);
                64'd3: drive_writeback(int'(pat[b+1][0]), b);
                64'd4: drive_mispredict(pat[b+1][IDX_W-1:0]);
                64'd5: stall_cycles = int'(pat[b+1][7:0]);
                64'd6: begin
                    gap = $random(seed);
                    repeat (int'(pat[b+1][7:0]) + (gap & 3)) @(negedge clock);
                end
                64'd7: begin
                    @(negedge clock);
                    check_value("full_disp_ready", pat[b+1], 64'(disp_ready));
                end
                default: ;
            endcase
        end
        repeat (20) @(negedge clock);
        checker_i.final_check();
        $display("errors: checker %0d, testbench %0d", checker_i.error_count, tb_errors);
        if (checker_i.error_count == 0 && tb_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rob_patterns.txt ====
// op a b c d: 1/2 dispatch wen/no wen (arch new old idx), 3 wb (port idx value), 4 mispredict (idx)
// 5 stall (cycles), 6 idle (cycles), 7 ready (expected), 8 commit (arch new old value), 9 free mask
3 0 5 dead 0
1 1 21 1 0
1 2 22 2 1
1 3 23 3 2
1 4 24 4 3
1 5 25 5 4
1 6 26 6 5
1 7 27 7 6
1 8 28 8 7
7 0 0 0 0
3 1 3 c3 0
3 0 1 c1 0
3 1 0 c0 0
3 0 2 c2 0
8 1 21 1 c0
8 2 22 2 c1
8 3 23 3 c2
8 4 24 4 c3
1 9 29 9 0
5 8 0 0 0
3 0 4 c4 0
3 1 5 c5 0
6 a 0 0 0
8 5 25 5 c4
8 6 26 6 c5
1 a 2a a 1
2 b 2b b 2
1 c 2c c 3
4 0 0 0 0
9 140000000000 0 0 0
1 d 2d d 1
3 0 2 bad 0
3 0 6 c6 0
3 1 7 c7 0
3 0 0 c9 0
3 1 1 cd 0
6 14 0 0 0
8 7 27 7 c6
8 8 28 8 c7
8 9 29 9 c9
8 d 2d d cd
0 0 0 0 0

// ==== tb.f ====
rob_pkg.sv
rob_entry_table.sv
rob_pointer_ctrl.sv
rob_flush_walk.sv
rob.sv
rob_checker.sv
tb_rob.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rob
FILELIST  ?= tb.f
PASS_MSG  := Everything OK

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
